// File: Makefile
SIM  := obj_dir/Valu_tb
SRCS := $(wildcard logic/*.sv sim/*.sv)

.PHONY: run clean

run: $(SIM) sim/alu_stimulus.txt
	$(SIM) > sim.log 2>&1; cat sim.log
	grep -qx "Test completed successfully" sim.log

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert --top-module alu_tb -f all.f -o Valu_tb

clean:
	rm -rf obj_dir sim.log

// File: all.f
logic/alu_op_pkg.sv
logic/alu_data_pkg.sv
logic/alu_shifter.sv
logic/alu_compare.sv
logic/alu_bit_count.sv
logic/alu_result_stage.sv
logic/alu_top.sv
sim/alu_clock_gen.sv
sim/alu_checker.sv
sim/alu_tb.sv

// File: logic/alu_bit_count.sv
`timescale 1ns/10ps

module alu_bit_count (
  input  alu_op_pkg::alu_opcode_e          op_i,
  input  alu_data_pkg::alu_word_t          operand_a_i,
  output logic [alu_data_pkg::CNT_W-1:0]   count_o
);
  import alu_op_pkg::*;
  import alu_data_pkg::*;

  alu_word_t        operand_rev;
  alu_word_t        scan_word;
  logic [CNT_W-1:0] lead_zeros;
  logic [CNT_W-1:0] pop_count;

  // Bit-reversed operand, so trailing zeros become leading zeros
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      operand_rev[i] = operand_a_i[XLEN-1-i];
    end
  end

  assign scan_word = (op_i == ALU_CTZ) ? operand_rev : operand_a_i;

  ////////////////////////////////////////////////////////////////////////////
  // Find first one from the top
  ////////////////////////////////////////////////////////////////////////////

  // Highest set bit wins, since later iterations override
  // No bit set leaves the count at 32
  always_comb begin
    lead_zeros = CNT_W'(XLEN);
    for (int i = 0; i < XLEN; i++) begin
      if (scan_word[i]) begin
        lead_zeros = CNT_W'(XLEN - 1 - i);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Population count
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    pop_count = '0;
    for (int i = 0; i < XLEN; i++) begin
      pop_count = pop_count + CNT_W'(operand_a_i[i]);
    end
  end

  // CLZ and CTZ share the scan
  always_comb begin
    case (op_i)
      ALU_CPOP: count_o = pop_count;
      default:  count_o = lead_zeros;
    endcase
  end

endmodule

// File: logic/alu_compare.sv
`timescale 1ns/10ps

module alu_compare (
  input  alu_op_pkg::alu_opcode_e      op_i,
  input  alu_data_pkg::alu_word_t      operand_a_i,
  input  alu_data_pkg::alu_word_t      operand_b_i,
  output alu_data_pkg::alu_word_t      sum_o,
  output alu_data_pkg::alu_cmp_flags_t flags_o,
  output logic                         cmp_o
);
  import alu_op_pkg::*;
  import alu_data_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////////////////////

  logic          sub_en;
  alu_word_t     adder_b;
  logic [XLEN:0] adder_in_a;
  logic [XLEN:0] adder_in_b;
  logic [XLEN:0] adder_out;

  assign sub_en  = (op_i == ALU_SUB);
  assign adder_b = sub_en ? ~operand_b_i : operand_b_i;

  // Extra low bit carries the +1 of the two's complement into bit 1
  assign adder_in_a = {operand_a_i, 1'b1};
  assign adder_in_b = {adder_b, sub_en};
  assign adder_out  = adder_in_a + adder_in_b;

  // Wraps modulo 2^32
  assign sum_o = adder_out[XLEN:1];

  ////////////////////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////////////////////

  logic cmp_signed;
  logic is_equal;
  logic is_greater;

  assign cmp_signed = (op_i == ALU_GES) || (op_i == ALU_LTS) || (op_i == ALU_SLTS) ||
                      (op_i == ALU_MIN) || (op_i == ALU_MAX);

  assign is_equal = (operand_a_i == operand_b_i);

  // One signed compare on 33 bits; the top bit is the sign only for signed forms
  assign is_greater = $signed({operand_a_i[XLEN-1] & cmp_signed, operand_a_i}) >
                      $signed({operand_b_i[XLEN-1] & cmp_signed, operand_b_i});

  assign flags_o.equal   = is_equal;
  assign flags_o.greater = is_greater;

  // Branch and set-less-than decision, equality otherwise
  always_comb begin
    cmp_o = is_equal;
    case (op_i)
      ALU_EQ:             cmp_o = is_equal;
      ALU_NE:             cmp_o = ~is_equal;
      ALU_GES, ALU_GEU:   cmp_o = is_greater | is_equal;
      ALU_LTS, ALU_LTU,
      ALU_SLTS, ALU_SLTU: cmp_o = ~(is_greater | is_equal);
      default: ;
    endcase
  end

endmodule

// File: logic/alu_data_pkg.sv
package alu_data_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // RV32 word
  localparam int XLEN    = 32;
  // Shift amount, one bit more than the word index for the 64-bit rotator
  localparam int SHAMT_W = 6;
  // Counts reach 32, so 6 bits
  localparam int CNT_W   = 6;

  typedef logic [XLEN-1:0] alu_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Request and response
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_pkg::alu_opcode_e op;
    alu_word_t               operand_a;
    alu_word_t               operand_b;
  } alu_req_t;

  typedef struct packed {
    alu_word_t result;
    logic      cmp;    // Branch decision bit
  } alu_rsp_t;

  // Compare flags shared by the branch logic and min/max
  typedef struct packed {
    logic equal;
    logic greater;  // Signed or unsigned, following the opcode
  } alu_cmp_flags_t;

endpackage

// File: logic/alu_op_pkg.sv
package alu_op_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operation encoding
  ////////////////////////////////////////////////////////////////////////////

  // Opcodes are grouped by unit, with gaps left between groups
  typedef enum logic [5:0] {
    // Bitwise logic, plain and with inverted operand b
    ALU_AND    = 6'h00,
    ALU_OR     = 6'h01,
    ALU_XOR    = 6'h02,
    ALU_ANDN   = 6'h03,
    ALU_ORN    = 6'h04,
    ALU_XNOR   = 6'h05,
    // Adder
    ALU_ADD    = 6'h08,
    ALU_SUB    = 6'h09,
    // Shifts and rotates
    ALU_SLL    = 6'h10,
    ALU_SRL    = 6'h11,
    ALU_SRA    = 6'h12,
    ALU_ROL    = 6'h13,
    ALU_ROR    = 6'h14,
    // Branch compares and set-less-than
    ALU_EQ     = 6'h18,
    ALU_NE     = 6'h19,
    ALU_GES    = 6'h1a,
    ALU_GEU    = 6'h1b,
    ALU_LTS    = 6'h1c,
    ALU_LTU    = 6'h1d,
    ALU_SLTS   = 6'h1e,
    ALU_SLTU   = 6'h1f,
    // Min and max
    ALU_MIN    = 6'h20,
    ALU_MINU   = 6'h21,
    ALU_MAX    = 6'h22,
    ALU_MAXU   = 6'h23,
    // Bit counts
    ALU_CLZ    = 6'h28,
    ALU_CTZ    = 6'h29,
    ALU_CPOP   = 6'h2a,
    // Byte operations
    ALU_SEXT_B = 6'h30,
    ALU_SEXT_H = 6'h31,
    ALU_REV8   = 6'h32,
    ALU_ORC_B  = 6'h33,
    // Single-bit operations
    ALU_BSET   = 6'h38,
    ALU_BCLR   = 6'h39,
    ALU_BINV   = 6'h3a,
    ALU_BEXT   = 6'h3b
  } alu_opcode_e;

  // Decoded shifter controls
  typedef struct packed {
    logic rshift;     // Right shift, done as a left rotate by the negated amount
    logic arithmetic; // Fill with the sign bit
    logic rotate;     // Fill with the operand itself
    logic tieoff;     // Shift a single one, for bit masks
  } alu_shift_ctrl_t;

endpackage

// File: logic/alu_result_stage.sv
`timescale 1ns/10ps

module alu_result_stage (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                valid_i,
  input  alu_data_pkg::alu_req_t              req_i,
  input  alu_data_pkg::alu_word_t             sh_result_i,
  input  alu_data_pkg::alu_word_t             bit_result_i,
  input  alu_data_pkg::alu_word_t             sum_i,
  input  alu_data_pkg::alu_cmp_flags_t        flags_i,
  input  logic                                cmp_i,
  input  logic [alu_data_pkg::CNT_W-1:0]      count_i,
  output logic                                valid_o,
  output alu_data_pkg::alu_rsp_t              rsp_o
);
  import alu_op_pkg::*;
  import alu_data_pkg::*;

  alu_word_t a;
  alu_word_t b;
  alu_word_t min_word;
  alu_word_t max_word;
  alu_rsp_t  rsp_d;

  assign a = req_i.operand_a;
  assign b = req_i.operand_b;

  // Greater flag already follows signedness of the opcode
  assign min_word = flags_i.greater ? b : a;
  assign max_word = flags_i.greater ? a : b;

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rsp_d.result = '0;
    rsp_d.cmp    = cmp_i;
    unique case (req_i.op)
      ALU_AND:  rsp_d.result = a & b;
      ALU_OR:   rsp_d.result = a | b;
      ALU_XOR:  rsp_d.result = a ^ b;
      ALU_ANDN: rsp_d.result = a & ~b;
      ALU_ORN:  rsp_d.result = a | ~b;
      ALU_XNOR: rsp_d.result = a ^ ~b;

      ALU_ADD, ALU_SUB: rsp_d.result = sum_i;

      ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_ROL, ALU_ROR: rsp_d.result = sh_result_i;

      // Branch compares only drive the cmp bit
      ALU_EQ, ALU_NE, ALU_GES, ALU_GEU,
      ALU_LTS, ALU_LTU: rsp_d.result = '0;

      ALU_SLTS, ALU_SLTU: rsp_d.result = {{(XLEN-1){1'b0}}, cmp_i};

      ALU_MIN, ALU_MINU: rsp_d.result = min_word;
      ALU_MAX, ALU_MAXU: rsp_d.result = max_word;

      ALU_CLZ, ALU_CTZ,
      ALU_CPOP: rsp_d.result = {{(XLEN-CNT_W){1'b0}}, count_i};

      ALU_SEXT_B: rsp_d.result = {{24{a[7]}}, a[7:0]};
      ALU_SEXT_H: rsp_d.result = {{16{a[15]}}, a[15:0]};
      // Byte swap
      ALU_REV8:   rsp_d.result = {a[7:0], a[15:8], a[23:16], a[31:24]};
      // Any set bit fills its whole byte
      ALU_ORC_B:  rsp_d.result = {{8{|a[31:24]}}, {8{|a[23:16]}},
                                  {8{|a[15:8]}}, {8{|a[7:0]}}};

      ALU_BSET, ALU_BCLR,
      ALU_BINV, ALU_BEXT: rsp_d.result = bit_result_i;

      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  // Valid follows the input strobe every cycle
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Response loads only on a valid request, otherwise holds
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rsp_o <= '0;
    end else if (valid_i) begin
      rsp_o <= rsp_d;
    end
  end

endmodule

// File: logic/alu_shifter.sv
`timescale 1ns/10ps

module alu_shifter (
  input  alu_op_pkg::alu_opcode_e op_i,
  input  alu_data_pkg::alu_word_t operand_a_i,
  input  alu_data_pkg::alu_word_t operand_b_i,
  output alu_data_pkg::alu_word_t sh_result_o,
  output alu_data_pkg::alu_word_t bit_result_o
);
  import alu_op_pkg::*;
  import alu_data_pkg::*;

  alu_shift_ctrl_t    ctrl;
  logic [SHAMT_W-1:0] shamt;
  alu_word_t          low_in;
  alu_word_t          fill_word;
  logic [2*XLEN-1:0]  pair;

  // Opcode decode into shifter controls
  always_comb begin
    ctrl = '0;
    case (op_i)
      ALU_SRL: ctrl.rshift = 1'b1;
      ALU_SRA: begin
        ctrl.rshift     = 1'b1;
        ctrl.arithmetic = 1'b1;
      end
      ALU_ROL: ctrl.rotate = 1'b1;
      ALU_ROR: begin
        ctrl.rshift = 1'b1;
        ctrl.rotate = 1'b1;
      end
      // Masks are a single one moved to the bit index
      ALU_BSET, ALU_BCLR, ALU_BINV: ctrl.tieoff = 1'b1;
      // Extract shifts a itself right, bit 0 then holds the result
      ALU_BEXT: ctrl.rshift = 1'b1;
      default: ;
    endcase
  end

  // Only the low 5 bits of b count; right shifts negate the amount
  always_comb begin
    shamt = {1'b0, operand_b_i[4:0]};
    if (ctrl.rshift) begin
      shamt = -shamt;
    end
  end

  // Low half is the operand, high half is what shifts in
  assign low_in = ctrl.tieoff ? alu_word_t'(1) : operand_a_i;

  always_comb begin
    if (ctrl.tieoff) begin
      fill_word = '0;
    end else if (ctrl.rotate) begin
      fill_word = operand_a_i;
    end else if (ctrl.arithmetic) begin
      fill_word = {XLEN{operand_a_i[XLEN-1]}};
    end else begin
      fill_word = '0;
    end
  end

  // Six rotate stages, largest step first
  always_comb begin
    pair = {fill_word, low_in};
    for (int i = SHAMT_W - 1; i >= 0; i--) begin
      if (shamt[i]) begin
        pair = (pair << (1 << i)) | (pair >> (2 * XLEN - (1 << i)));
      end
    end
  end

  assign sh_result_o = pair[XLEN-1:0];

  // Single-bit results from the mask or the shifted operand
  always_comb begin
    bit_result_o = '0;
    case (op_i)
      ALU_BSET: bit_result_o = operand_a_i | sh_result_o;
      ALU_BCLR: bit_result_o = operand_a_i & ~sh_result_o;
      ALU_BINV: bit_result_o = operand_a_i ^ sh_result_o;
      ALU_BEXT: bit_result_o = {{(XLEN-1){1'b0}}, sh_result_o[0]};
      default: ;
    endcase
  end

endmodule

// File: logic/alu_top.sv
`timescale 1ns/10ps

module alu_top (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   valid_i,
  input  alu_data_pkg::alu_req_t req_i,
  output logic                   valid_o,
  output alu_data_pkg::alu_rsp_t rsp_o
);
  import alu_data_pkg::*;

  // Results of the combinational units
  alu_word_t        sh_result;
  alu_word_t        bit_result;
  alu_word_t        sum;
  alu_cmp_flags_t   flags;
  logic             cmp;
  logic [CNT_W-1:0] count;

  // Shifts, rotates and single-bit operations
  alu_shifter shifter_i (
    .op_i         (req_i.op),
    .operand_a_i  (req_i.operand_a),
    .operand_b_i  (req_i.operand_b),
    .sh_result_o  (sh_result),
    .bit_result_o (bit_result)
  );

  // Adder and compares
  alu_compare compare_i (
    .op_i        (req_i.op),
    .operand_a_i (req_i.operand_a),
    .operand_b_i (req_i.operand_b),
    .sum_o       (sum),
    .flags_o     (flags),
    .cmp_o       (cmp)
  );

  // CLZ, CTZ and CPOP
  alu_bit_count bit_count_i (
    .op_i        (req_i.op),
    .operand_a_i (req_i.operand_a),
    .count_o     (count)
  );

  // Select and register, one cycle
  alu_result_stage result_stage_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .valid_i      (valid_i),
    .req_i        (req_i),
    .sh_result_i  (sh_result),
    .bit_result_i (bit_result),
    .sum_i        (sum),
    .flags_i      (flags),
    .cmp_i        (cmp),
    .count_i      (count),
    .valid_o      (valid_o),
    .rsp_o        (rsp_o)
  );

endmodule

// File: sim/alu_checker.sv
`timescale 1ns/10ps

module alu_checker (
  input logic                   clk,
  input logic                   rst_n_i,
  input logic                   valid_in_i,
  input logic                   valid_out_i,
  input alu_data_pkg::alu_rsp_t rsp_i
);

  // High from the first edge on, so $past has a history
  logic past_valid;

  initial begin
    past_valid = 1'b0;
  end

  always @(posedge clk) begin
    past_valid <= 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid and hold timing
  ////////////////////////////////////////////////////////////////////////////

  // Output valid is the input strobe one cycle later
  valid_follows_input: assert property (@(posedge clk)
    (past_valid && $past(rst_n_i)) |-> (valid_out_i == $past(valid_in_i)))
    else $error("valid_o is not valid_i delayed by one cycle");

  // Reset clears valid
  valid_low_after_reset: assert property (@(posedge clk)
    (past_valid && !$past(rst_n_i)) |-> !valid_out_i)
    else $error("valid_o is high in the cycle after reset");

  // No load without valid, response holds
  rsp_holds_when_idle: assert property (@(posedge clk)
    (past_valid && $past(rst_n_i) && !$past(valid_in_i)) |-> $stable(rsp_i))
    else $error("rsp_o changed after a cycle with valid_i low");

endmodule

// Attached to every alu_top
bind alu_top alu_checker checker_i (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .valid_in_i  (valid_i),
  .valid_out_i (valid_o),
  .rsp_i       (rsp_o)
);

// File: sim/alu_clock_gen.sv
`timescale 1ns/10ps

module alu_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #5 clk_o = ~clk_o;
    end
  end

  // Reset low over two rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: sim/alu_stimulus.txt
# test gap opcode operand_a operand_b result cmp
# test and gap are decimal, the other columns hex; gap 1 idles valid_i one cycle first
1 0 00 12345678 0f0f00ff 02040078 0
1 0 01 12345678 0f0f00ff 1f3f56ff 0
1 0 02 12345678 0f0f00ff 1d3b5687 0
1 0 03 12345678 0f0f00ff 10305600 0
1 0 04 12345678 0f0f00ff f2f4ff78 0
1 0 05 12345678 0f0f00ff e2c4a978 0
2 0 08 ffffffff 00000002 00000001 0
2 0 09 00000001 00000002 ffffffff 0
2 0 09 12345678 12345678 00000000 1
2 0 10 80000001 00000024 00000010 0
2 0 11 80000000 0000001f 00000001 0
2 0 12 80000010 00000004 f8000001 0
2 0 13 80000001 00000001 00000003 0
2 0 14 00000001 00000004 10000000 0
3 0 18 ffffffff 00000001 00000000 0
3 0 19 ffffffff 00000001 00000000 1
3 0 1a ffffffff 00000001 00000000 0
3 0 1b ffffffff 00000001 00000000 1
3 0 1c ffffffff 00000001 00000000 1
3 0 1d ffffffff 00000001 00000000 0
3 0 1e ffffffff 00000001 00000001 1
3 0 1f ffffffff 00000001 00000000 0
3 0 18 00000005 00000005 00000000 1
3 0 20 ffffffff 00000001 ffffffff 0
3 0 21 ffffffff 00000001 00000001 0
3 0 22 ffffffff 00000001 00000001 0
3 0 23 ffffffff 00000001 ffffffff 0
4 0 28 00000000 00000000 00000020 1
4 0 28 00010000 00000000 0000000f 0
4 0 29 00000000 00000001 00000020 0
4 0 29 00000100 00000000 00000008 0
4 0 2a f0f00001 00000000 00000009 0
4 0 30 12345680 00000000 ffffff80 0
4 0 31 12347fff 00000000 00007fff 0
4 0 32 11223344 00000000 44332211 0
4 0 33 00100080 00000000 00ff00ff 0
5 0 38 00000000 00000025 00000020 0
5 0 39 ffffffff 0000001f 7fffffff 0
5 0 3a 0000000f 00000003 00000007 0
5 0 3b 80000000 0000001f 00000001 0
6 1 08 00000010 00000020 00000030 0
6 1 02 aaaaaaaa 55555555 ffffffff 0
6 0 09 00000005 00000005 00000000 1

// File: sim/alu_tb.sv
`timescale 1ns/10ps

module alu_tb;
  import alu_op_pkg::*;
  import alu_data_pkg::*;

  // One line of the stimulus file
  typedef struct packed {
    logic [31:0] test;
    logic        gap;
    logic [5:0]  op;
    alu_word_t   operand_a;
    alu_word_t   operand_b;
    alu_word_t   result;
    logic        cmp;
  } vector_t;

  logic     clk;
  logic     rst_n;
  logic     valid;
  alu_req_t req;
  logic     dut_valid;
  alu_rsp_t dut_rsp;

  vector_t  vectors[$];
  bit       load_ok;
  int       cycles;
  int       cycle_limit;
  int       pass_count;
  int       fail_count;
  int       test_checks;
  int       test_fails;
  // Last expected response that rsp_o must hold through a gap
  alu_rsp_t held_rsp;

  alu_clock_gen clock_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  alu_top dut_i (
    .clk     (clk),
    .rst_n_i (rst_n),
    .valid_i (valid),
    .req_i   (req),
    .valid_o (dut_valid),
    .rsp_o   (dut_rsp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int          fd;
    int          fields;
    int          got;
    string       line;
    logic [31:0] tv;
    logic [31:0] gv;
    logic [31:0] ov;
    logic [31:0] av;
    logic [31:0] bv;
    logic [31:0] rv;
    logic [31:0] cv;
    vector_t     v;
    fd = $fopen("sim/alu_stimulus.txt", "r");
    load_ok = (fd != 0);
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        got = $fgets(line, fd);
        // Skip comment lines and anything short of seven fields
        if (got > 0 && line.len() > 0 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%d %d %h %h %h %h %h", tv, gv, ov, av, bv, rv, cv);
          if (fields == 7) begin
            v.test      = tv;
            v.gap       = gv[0];
            v.op        = ov[5:0];
            v.operand_a = av;
            v.operand_b = bv;
            v.result    = rv;
            v.cmp       = cv[0];
            vectors.push_back(v);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input alu_word_t got, input alu_word_t exp);
    test_checks++;
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      test_fails++;
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    test_checks++;
    if (got !== exp) begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      test_fails++;
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic report_test(input logic [31:0] num);
    $display("Test %0d done: %0d checks, %0d failed", num, test_checks, test_fails);
    test_checks = 0;
    test_fails  = 0;
  endtask

  // Idle cycle with new operands while the output stays put
  task automatic apply_gap(input vector_t v);
    valid         = 1'b0;
    req.operand_a = ~v.operand_a;
    @(negedge clk);
    check_bit("valid_o", dut_valid, 1'b0);
    check_word("rsp_o.result", dut_rsp.result, held_rsp.result);
    check_bit("rsp_o.cmp", dut_rsp.cmp, held_rsp.cmp);
  endtask

  task automatic apply_vector(input vector_t v);
    if (v.gap) begin
      apply_gap(v);
    end
    valid         = 1'b1;
    req.op        = alu_opcode_e'(v.op);
    req.operand_a = v.operand_a;
    req.operand_b = v.operand_b;
    // Sampled and registered by the next rising edge
    @(negedge clk);
    check_bit("valid_o", dut_valid, 1'b1);
    check_word("rsp_o.result", dut_rsp.result, v.result);
    check_bit("rsp_o.cmp", dut_rsp.cmp, v.cmp);
    held_rsp.result = v.result;
    held_rsp.cmp    = v.cmp;
  endtask

  // Run limit from the vector count
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] cur_test;
    // Strobe stays high through reset while valid_o and rsp_o must stay clear
    valid       = 1'b1;
    req         = '0;
    held_rsp    = '0;
    cycles      = 0;
    pass_count  = 0;
    fail_count  = 0;
    test_checks = 0;
    test_fails  = 0;
    cycle_limit = 20;
    load_vectors();
    cycle_limit = 10 * vectors.size() + 20;
    if (!load_ok || vectors.size() == 0) begin
      $display("Could not read any vectors from sim/alu_stimulus.txt");
      $display("Test failed");
      $finish;
    end else begin
      // Release comes on a falling edge, the state left by reset is test 0
      @(posedge rst_n);
      check_bit("valid_o", dut_valid, 1'b0);
      check_word("rsp_o.result", dut_rsp.result, '0);
      check_bit("rsp_o.cmp", dut_rsp.cmp, 1'b0);
      report_test(0);
      cur_test = vectors[0].test;
      foreach (vectors[i]) begin
        if (vectors[i].test != cur_test) begin
          report_test(cur_test);
          cur_test = vectors[i].test;
        end
        apply_vector(vectors[i]);
      end
      // Trailing idle cycle drops valid and keeps the last result
      apply_gap(vectors[vectors.size() - 1]);
      report_test(cur_test);
      $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule
